// ==== Makefile ====
# Verilator build and run for the AES output path testbench.
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := aes_out_path_tb
FILELIST  := aes_out_path.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== aes_out_path.f ====
design/aes_out_pkg.sv
design/block_fifo.sv
design/aes_block_packer.sv
design/aes_axis_master.sv
design/aes_out_path.sv
dv/aes_out_path_tb.sv

// ==== design/aes_axis_master.sv ====
// AXI4-Stream block serializer
`default_nettype none
`timescale 1ns/1ns

module aes_axis_master (
	input  wire                                    m00_axis_aclk,
	input  wire                                    rst_n,

	// FIFO read side.
	input  wire                                    rd_valid,
	input  aes_out_pkg::aes_block_t                rd_block,
	output logic                                   pop,

	// AXI4-Stream master.
	output logic                                   m00_axis_tvalid,
	output aes_out_pkg::word_t                     m00_axis_tdata,
	output logic [aes_out_pkg::word_w/8-1:0]       m00_axis_tstrb,
	output logic                                   m00_axis_tlast,
	input  wire                                    m00_axis_tready
);

	localparam int BEAT_W = $clog2(aes_out_pkg::nb);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(aes_out_pkg::nb - 1);

	aes_out_pkg::aes_block_t blk_q;
	logic [BEAT_W-1:0]       beat_cnt;
	logic                    tvalid_q;

	logic beat;
	logic final_beat;

	// ------------------------------------------------------------------------
	// handshake decode.
	// ------------------------------------------------------------------------

	// take a new block only once the output register is idle.
	assign pop = rd_valid && !tvalid_q;

	assign beat       = tvalid_q && m00_axis_tready;
	assign final_beat = beat && (beat_cnt == LAST_BEAT);

	// ------------------------------------------------------------------------
	// stream outputs.
	// ------------------------------------------------------------------------

	// low word goes out first.
	assign m00_axis_tdata = blk_q.data[beat_cnt*aes_out_pkg::word_w +: aes_out_pkg::word_w];

	// every byte lane always carries data.
	assign m00_axis_tstrb  = {(aes_out_pkg::word_w/8){1'b1}};
	assign m00_axis_tvalid = tvalid_q;
	assign m00_axis_tlast  = blk_q.last && (beat_cnt == LAST_BEAT);

	// ------------------------------------------------------------------------
	// beat control.
	// ------------------------------------------------------------------------

	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			tvalid_q <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (pop) begin
				tvalid_q <= 1'b1;
			end else if (final_beat) begin
				tvalid_q <= 1'b0;
			end

			// counter wraps to zero on the last beat.
			if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// block held for the whole burst.
	always_ff @(posedge m00_axis_aclk) begin
		if (pop) begin
			blk_q <= rd_block;
		end
	end

endmodule

`default_nettype wire

// ==== design/aes_block_packer.sv ====
// AES block packer
`default_nettype none
`timescale 1ns/1ns

module aes_block_packer (
	input  wire                      m00_axis_aclk,
	input  wire                      rst_n,

	// incoming state words.
	input  wire                      word_valid,
	input  aes_out_pkg::word_t       word_data,
	input  wire                      word_last,
	input  wire [aes_out_pkg::block_w-1:0] round_key,
	output logic                     word_ready,

	// block write side.
	output logic                     wr_valid,
	output aes_out_pkg::aes_block_t  wr_block,
	input  wire                      wr_ready
);

	localparam int IDX_W = $clog2(aes_out_pkg::nb);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(aes_out_pkg::nb - 1);
	localparam int LOW_W = aes_out_pkg::block_w - aes_out_pkg::word_w;

	logic [IDX_W-1:0]        word_idx;
	logic                    wr_valid_q;
	aes_out_pkg::aes_block_t blk_q;

	logic word_take;
	logic block_done;
	logic wr_take;

	// ------------------------------------------------------------------------
	// handshake decode.
	// ------------------------------------------------------------------------

	// no new words while a finished block waits for the FIFO.
	assign word_ready = !wr_valid_q;
	assign word_take  = word_valid && word_ready;
	assign block_done = word_take && (word_idx == LAST_IDX);
	assign wr_take    = wr_valid_q && wr_ready;

	assign wr_valid = wr_valid_q;
	assign wr_block = blk_q;

	// ------------------------------------------------------------------------
	// control state.
	// ------------------------------------------------------------------------

	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			word_idx   <= '0;
			wr_valid_q <= 1'b0;
		end else begin
			// index wraps back to slot 0 after the fourth word.
			if (word_take) begin
				word_idx <= word_idx + 1'b1;
			end

			if (block_done) begin
				wr_valid_q <= 1'b1;
			end else if (wr_take) begin
				wr_valid_q <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// block assembly.
	// ------------------------------------------------------------------------

	always_ff @(posedge m00_axis_aclk) begin
		if (word_take) begin
			if (word_idx == LAST_IDX) begin
				// final AddRoundKey over the whole block.
				blk_q.data <= {word_data, blk_q.data[LOW_W-1:0]} ^ round_key;
				blk_q.last <= word_last;
			end else begin
				blk_q.data[word_idx*aes_out_pkg::word_w +: aes_out_pkg::word_w] <= word_data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/aes_out_path.sv ====
// AES output path top level
`default_nettype none
`timescale 1ns/1ns

module aes_out_path #(
	parameter int FIFO_DEPTH = 16,
	parameter int AF_LEVEL   = 12
) (
	input  wire                                    m00_axis_aclk,
	input  wire                                    rst_n,

	// cipher state input.
	input  wire                                    word_valid,
	input  aes_out_pkg::word_t                     word_data,
	input  wire                                    word_last,
	input  wire [aes_out_pkg::block_w-1:0]         round_key,
	output logic                                   word_ready,

	// AXI4-Stream master.
	output logic                                   m00_axis_tvalid,
	output aes_out_pkg::word_t                     m00_axis_tdata,
	output logic [aes_out_pkg::word_w/8-1:0]       m00_axis_tstrb,
	output logic                                   m00_axis_tlast,
	input  wire                                    m00_axis_tready,

	// FIFO status.
	output logic                                   fifo_full,
	output logic                                   fifo_empty,
	output logic                                   fifo_almost_full
);

	// ------------------------------------------------------------------------
	// packer to FIFO.
	// ------------------------------------------------------------------------

	logic                    wr_valid;
	logic                    wr_ready;
	aes_out_pkg::aes_block_t wr_block;

	// FIFO to stream master.
	logic                    rd_valid;
	logic                    pop;
	aes_out_pkg::aes_block_t rd_block;

	aes_block_packer u_packer (
		.m00_axis_aclk (m00_axis_aclk),
		.rst_n         (rst_n),
		.word_valid    (word_valid),
		.word_data     (word_data),
		.word_last     (word_last),
		.round_key     (round_key),
		.word_ready    (word_ready),
		.wr_valid      (wr_valid),
		.wr_block      (wr_block),
		.wr_ready      (wr_ready)
	);

	block_fifo #(
		.payload_t (aes_out_pkg::aes_block_t),
		.DEPTH     (FIFO_DEPTH),
		.AF_LEVEL  (AF_LEVEL)
	) u_fifo (
		.m00_axis_aclk (m00_axis_aclk),
		.rst_n         (rst_n),
		.wr_valid      (wr_valid),
		.wr_data       (wr_block),
		.wr_ready      (wr_ready),
		.pop           (pop),
		.rd_valid      (rd_valid),
		.rd_data       (rd_block),
		.full          (fifo_full),
		.empty         (fifo_empty),
		.almost_full   (fifo_almost_full)
	);

	aes_axis_master u_master (
		.m00_axis_aclk   (m00_axis_aclk),
		.rst_n           (rst_n),
		.rd_valid        (rd_valid),
		.rd_block        (rd_block),
		.pop             (pop),
		.m00_axis_tvalid (m00_axis_tvalid),
		.m00_axis_tdata  (m00_axis_tdata),
		.m00_axis_tstrb  (m00_axis_tstrb),
		.m00_axis_tlast  (m00_axis_tlast),
		.m00_axis_tready (m00_axis_tready)
	);

endmodule

`default_nettype wire

// ==== design/aes_out_pkg.sv ====
// AES output path definitions
`default_nettype none

package aes_out_pkg;

	// ------------------------------------------------------------------------
	// state sizes.
	// ------------------------------------------------------------------------

	// one column of the AES state.
	localparam int word_w = 32;

	// columns per block.
	localparam int nb = 4;

	// full block width.
	localparam int block_w = word_w * nb;

	typedef logic [word_w-1:0] word_t;

	// ------------------------------------------------------------------------
	// block payload.
	// ------------------------------------------------------------------------

	// one finished cipher block on its way to the stream port.
	// word 0 sits in data[31:0] and goes out first.
	typedef struct packed {
		logic               last;
		logic [block_w-1:0] data;
	} aes_block_t;

endpackage

`default_nettype wire

// ==== design/block_fifo.sv ====
// Circular block FIFO
`default_nettype none
`timescale 1ns/1ns

module block_fifo #(
	parameter type payload_t = aes_out_pkg::aes_block_t,
	parameter int  DEPTH     = 16,
	parameter int  AF_LEVEL  = 12
) (
	input  wire      m00_axis_aclk,
	input  wire      rst_n,

	// write side.
	input  wire      wr_valid,
	input  payload_t wr_data,
	output logic     wr_ready,

	// show-ahead read side.
	input  wire      pop,
	output logic     rd_valid,
	output payload_t rd_data,

	// status levels.
	output logic     full,
	output logic     empty,
	output logic     almost_full
);

	localparam int ADDR_W = $clog2(DEPTH);
	localparam int CNT_W  = $clog2(DEPTH + 1);
	localparam logic [CNT_W-1:0] AF_CNT = CNT_W'(AF_LEVEL);

	payload_t mem [DEPTH];

	// extra top bit tells a full ring from an empty one.
	logic [ADDR_W:0]  wr_ptr;
	logic [ADDR_W:0]  rd_ptr;
	logic [CNT_W-1:0] count;

	logic wr_en;
	logic rd_en;

	// ------------------------------------------------------------------------
	// level decode.
	// ------------------------------------------------------------------------

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
	               (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
	assign almost_full = (count >= AF_CNT);

	assign wr_ready = !full;
	assign rd_valid = !empty;
	assign rd_data  = mem[rd_ptr[ADDR_W-1:0]];

	assign wr_en = wr_valid && wr_ready;
	assign rd_en = pop && rd_valid;

	// ------------------------------------------------------------------------
	// pointers and occupancy.
	// ------------------------------------------------------------------------

	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// read and write together leave the count alone.
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage.
	always_ff @(posedge m00_axis_aclk) begin
		if (wr_en) begin
			mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== dv/aes_out_path_tb.sv ====
// AES output path testbench
`default_nettype none
`timescale 1ns/1ns

module aes_out_path_tb;

	localparam int CLK_HALF     = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES   = 4000;

	logic                             m00_axis_aclk = 1'b0;
	logic                             rst_n;
	logic                             word_valid;
	aes_out_pkg::word_t               word_data;
	logic                             word_last;
	logic [aes_out_pkg::block_w-1:0]  round_key;
	logic                             word_ready;
	logic                             m00_axis_tvalid;
	aes_out_pkg::word_t               m00_axis_tdata;
	logic [3:0]                       m00_axis_tstrb;
	logic                             m00_axis_tlast;
	logic                             m00_axis_tready = 1'b1;
	logic                             fifo_full;
	logic                             fifo_empty;
	logic                             fifo_almost_full;

	// blocks still owed by the DUT in the order they were sent.
	aes_out_pkg::aes_block_t exp_q[$];

	integer      seed   = 79;
	int          cycles = 0;
	logic [1:0]  ready_mode;
	logic [31:0] ready_rnd;

	logic               stalled = 1'b0;
	aes_out_pkg::word_t stall_data;
	logic               stall_last;

	aes_out_path #(
		.FIFO_DEPTH (4),
		.AF_LEVEL   (3)
	) UUT (
		.m00_axis_aclk    (m00_axis_aclk),
		.rst_n            (rst_n),
		.word_valid       (word_valid),
		.word_data        (word_data),
		.word_last        (word_last),
		.round_key        (round_key),
		.word_ready       (word_ready),
		.m00_axis_tvalid  (m00_axis_tvalid),
		.m00_axis_tdata   (m00_axis_tdata),
		.m00_axis_tstrb   (m00_axis_tstrb),
		.m00_axis_tlast   (m00_axis_tlast),
		.m00_axis_tready  (m00_axis_tready),
		.fifo_full        (fifo_full),
		.fifo_empty       (fifo_empty),
		.fifo_almost_full (fifo_almost_full)
	);

	always #CLK_HALF m00_axis_aclk = ~m00_axis_aclk;

	// ------------------------------------------------------------------------
	// sink ready, watchdog and stall monitor.
	// ------------------------------------------------------------------------

	// mode 0 holds the sink off, 1 keeps it ready, 2 picks ready at random.
	always @(posedge m00_axis_aclk) begin
		case (ready_mode)
			2'd0: m00_axis_tready <= 1'b0;
			2'd1: m00_axis_tready <= 1'b1;
			default: begin
				ready_rnd = $random(seed);
				m00_axis_tready <= ready_rnd[0];
			end
		endcase
	end

	always @(posedge m00_axis_aclk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles.", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "simulation timed out");
		end
	end

	// a stalled beat must be offered again unchanged.
	always @(posedge m00_axis_aclk) begin
		if (stalled) begin
			check_eq(128'(m00_axis_tvalid), 128'(1'b1), "m00_axis_tvalid");
			check_eq(128'(m00_axis_tdata), 128'(stall_data), "m00_axis_tdata");
			check_eq(128'(m00_axis_tlast), 128'(stall_last), "m00_axis_tlast");
		end
		stalled    = rst_n && m00_axis_tvalid && !m00_axis_tready;
		stall_data = m00_axis_tdata;
		stall_last = m00_axis_tlast;
	end

	// ------------------------------------------------------------------------
	// drive and check tasks.
	// ------------------------------------------------------------------------

	task automatic check_eq(input logic [127:0] actual, input logic [127:0] expected,
	                        input string name);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// each output word is the input word XOR its key slice.
	task automatic send_block(input logic [127:0] data, input logic last,
	                          input logic [127:0] key);
		aes_out_pkg::aes_block_t blk;
		blk.data = data ^ key;
		blk.last = last;
		exp_q.push_back(blk);
		@(posedge m00_axis_aclk);
		while (!word_ready) begin
			@(posedge m00_axis_aclk);
		end
		round_key <= key;
		for (int i = 0; i < 4; i++) begin
			word_valid <= 1'b1;
			word_data  <= data[i*32 +: 32];
			word_last  <= last && (i == 3);
			@(posedge m00_axis_aclk);
		end
		word_valid <= 1'b0;
		word_last  <= 1'b0;
	endtask

	task automatic expect_block();
		aes_out_pkg::aes_block_t blk;
		int beat;
		beat = 0;
		while (exp_q.size() == 0) begin
			@(posedge m00_axis_aclk);
		end
		blk = exp_q.pop_front();
		while (beat < 4) begin
			@(posedge m00_axis_aclk);
			if (m00_axis_tvalid && m00_axis_tready) begin
				check_eq(128'(m00_axis_tdata), 128'(blk.data[beat*32 +: 32]), "m00_axis_tdata");
				check_eq(128'(m00_axis_tlast), 128'(blk.last && (beat == 3)), "m00_axis_tlast");
				check_eq(128'(m00_axis_tstrb), 128'(4'hf), "m00_axis_tstrb");
				beat++;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// tests.
	// ------------------------------------------------------------------------

	task automatic after_reset();
		@(posedge m00_axis_aclk);
		check_eq(128'(m00_axis_tvalid), 128'(1'b0), "m00_axis_tvalid");
		check_eq(128'(m00_axis_tlast), 128'(1'b0), "m00_axis_tlast");
		check_eq(128'(fifo_empty), 128'(1'b1), "fifo_empty");
		check_eq(128'(fifo_full), 128'(1'b0), "fifo_full");
		check_eq(128'(fifo_almost_full), 128'(1'b0), "fifo_almost_full");
		check_eq(128'(word_ready), 128'(1'b1), "word_ready");
	endtask

	task automatic single_block_message();
		send_block(128'h44444444_33333333_22222222_11111111, 1'b1, '0);
		expect_block();
	endtask

	task automatic key_addition();
		send_block(128'h3243f6a8_885a308d_313198a2_e0370734, 1'b1,
		           128'h2b7e1516_28aed2a6_abf71588_09cf4f3c);
		expect_block();
	endtask

	// a three-block message followed by a one-block message.
	task automatic two_messages();
		logic [127:0] key;
		key = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
		fork
			begin
				send_block(128'h000000a3_000000a2_000000a1_000000a0, 1'b0, key);
				send_block(128'h000000b3_000000b2_000000b1_000000b0, 1'b0, key);
				send_block(128'h000000c3_000000c2_000000c1_000000c0, 1'b1, key);
				send_block(128'h000000d3_000000d2_000000d1_000000d0, 1'b1, key);
			end
			repeat (4) begin
				expect_block();
			end
		join
	endtask

	task automatic random_backpressure();
		logic [127:0] data [8];
		logic [127:0] key;
		key = 128'h13579bdf_2468ace0_fedcba98_76543210;
		for (int b = 0; b < 8; b++) begin
			for (int w = 0; w < 4; w++) begin
				data[b][w*32 +: 32] = $random(seed);
			end
		end
		ready_mode <= 2'd2;
		fork
			for (int b = 0; b < 8; b++) begin
				send_block(data[b], (b % 4) == 3, key);
			end
			repeat (8) begin
				expect_block();
			end
		join
		ready_mode <= 2'd1;
	endtask

	// one block in the master, four in the FIFO, the sixth held in the packer.
	task automatic fill_and_drain();
		logic [127:0] data;
		logic [127:0] key;
		int held;
		key = 128'hc0c1c2c3_c4c5c6c7_c8c9cacb_cccdcecf;
		ready_mode <= 2'd0;
		@(posedge m00_axis_aclk);
		for (int k = 1; k <= 6; k++) begin
			for (int w = 0; w < 4; w++) begin
				data[w*32 +: 32] = $random(seed);
			end
			send_block(data, k == 6, key);
			repeat (4) @(posedge m00_axis_aclk);
			held = (k <= 5) ? k - 1 : 4;
			check_eq(128'(fifo_almost_full), 128'(held >= 3), "fifo_almost_full");
			check_eq(128'(fifo_full), 128'(held == 4), "fifo_full");
			check_eq(128'(fifo_empty), 128'(held == 0), "fifo_empty");
			check_eq(128'(m00_axis_tvalid), 128'(1'b1), "m00_axis_tvalid");
			check_eq(128'(word_ready), 128'(k < 6), "word_ready");
		end
		ready_mode <= 2'd1;
		repeat (6) begin
			expect_block();
		end
		@(posedge m00_axis_aclk);
		check_eq(128'(fifo_empty), 128'(1'b1), "fifo_empty");
		check_eq(128'(m00_axis_tvalid), 128'(1'b0), "m00_axis_tvalid");
		check_eq(128'(word_ready), 128'(1'b1), "word_ready");
	endtask

	initial begin
		rst_n      <= 1'b0;
		word_valid <= 1'b0;
		word_data  <= '0;
		word_last  <= 1'b0;
		round_key  <= '0;
		ready_mode <= 2'd1;
		repeat (RESET_CYCLES) @(posedge m00_axis_aclk);
		rst_n <= 1'b1;

		after_reset();
		single_block_message();
		key_addition();
		two_messages();
		random_backpressure();
		fill_and_drain();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
